// File: nes_bus_pkg.sv
// NES CPU bus package with widths, register addresses, bus structs and the DMA address union
package nes_bus_pkg;

	typedef logic [15:0] addr_t;    // CPU address
	typedef logic [7:0]  data_t;    // Data byte

	// Fixed registers from the NES memory map
	localparam addr_t OAM_DATA_ADDR   = 16'h2004;  // Sprite memory write port
	localparam addr_t OAM_DMA_ADDR    = 16'h4014;  // Sprite DMA page trigger
	localparam addr_t APU_STATUS_ADDR = 16'h4015;
	localparam addr_t JOY1_ADDR       = 16'h4016;  // Joypad 1 read, strobe write
	localparam addr_t JOY2_ADDR       = 16'h4017;  // Joypad 2 read

	// PPU registers, mirrored every 8 bytes
	localparam addr_t PPU_BASE = 16'h2000;
	localparam addr_t PPU_END  = 16'h3FFF;

	// APU and I/O registers
	localparam addr_t APU_BASE = 16'h4000;
	localparam addr_t APU_END  = 16'h4017;

	localparam int JOY_BITS = 5;    // Serial joypad lines per port

	// One bus cycle, CPU side or granted
	typedef struct packed {
		addr_t addr;
		data_t data;    // Write data
		logic  read;
		logic  write;
	} bus_req_t;

	// DMA bus request
	typedef struct packed {
		logic  enable;  // DMA owns the bus
		addr_t addr;
		data_t data;    // Byte written to OAM
		logic  read;    // Low means write
	} dma_req_t;

	// Decoded chip selects
	typedef struct packed {
		logic ppu;
		logic apu;
		logic apu_status;
		logic joy1;
		logic joy2;
		logic prg;      // Cartridge, all space outside PPU and APU
	} chip_sel_t;

	// Sprite DMA source is page:offset, DMC and bus want a flat address
	typedef struct packed {
		data_t page;
		data_t offset;
	} page_off_t;

	typedef union packed {
		addr_t     flat;
		page_off_t po;
	} dma_addr_u;

endpackage

// File: cpu_bus_decode.sv
// Bus master select, chip select decode and joypad strobe/clock for the NES CPU bus
`timescale 1ns/1ps

module cpu_bus_decode (
	input  logic                 clk,
	input  logic                 reset,
	input  nes_bus_pkg::bus_req_t cpu_req,
	input  nes_bus_pkg::dma_req_t dma_req,
	output nes_bus_pkg::bus_req_t bus,
	output nes_bus_pkg::chip_sel_t sel,
	output logic                 sprite_trigger,
	output logic [2:0]           joypad_out,
	output logic [1:0]           joypad_clock
);
	import nes_bus_pkg::*;

	// DMA takes the bus whenever it asks
	always_comb begin
		if (dma_req.enable) begin
			bus.addr  = dma_req.addr;
			bus.data  = dma_req.data;
			bus.read  = dma_req.read;
			bus.write = !dma_req.read;  // DMA cycles are read or write, never idle
		end else begin
			bus = cpu_req;
		end
	end

	// Chip selects from the granted address
	always_comb begin
		sel.ppu        = (bus.addr >= PPU_BASE) && (bus.addr <= PPU_END);
		sel.apu        = (bus.addr >= APU_BASE) && (bus.addr <= APU_END);
		sel.apu_status = (bus.addr == APU_STATUS_ADDR);
		sel.joy1       = (bus.addr == JOY1_ADDR);
		sel.joy2       = (bus.addr == JOY2_ADDR);
		sel.prg        = !sel.ppu && !sel.apu;  // Cart sees everything else
	end

	// Write of the page byte to $4014 starts sprite DMA
	assign sprite_trigger = bus.write && (bus.addr == OAM_DMA_ADDR);

	// Joypad strobe latch, bits 2:0 of a $4016 write
	always_ff @(posedge clk) begin
		if (reset) begin
			joypad_out <= 3'b000;
		end else if (sel.joy1 && bus.write) begin
			joypad_out <= bus.data[2:0];
		end
	end

	// Each read shifts the matching pad
	assign joypad_clock = {sel.joy2 && bus.read, sel.joy1 && bus.read};

	// DMA writes only ever land on the OAM data port
	a_dma_write_oam: assert property (
		@(posedge clk) disable iff (reset)
		(dma_req.enable && !dma_req.read) |-> (bus.addr == OAM_DATA_ADDR)
	) else $error("cpu_bus_decode: DMA write outside the OAM data port");

endmodule

// File: sprite_dmc_dma.sv
// Sprite and DMC DMA controller with even/odd CPU cycle tracking
`timescale 1ns/1ps

module sprite_dmc_dma (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  cpu_ce,
	input  logic                  sprite_trigger,
	input  nes_bus_pkg::data_t    page_data,     // Byte written to $4014
	input  logic                  cpu_read,
	input  logic                  dmc_trigger,
	input  nes_bus_pkg::addr_t    dmc_addr,
	input  nes_bus_pkg::data_t    rd_data,
	output nes_bus_pkg::dma_req_t dma_req,
	output logic                  dmc_ack,
	output logic                  pause_cpu
);
	import nes_bus_pkg::*;

	// Sprite states, bit 0 pauses the CPU, bit 1 owns the bus
	localparam logic [1:0] SPR_IDLE = 2'd0;
	localparam logic [1:0] SPR_WAIT = 2'd1;  // Waiting for an odd read cycle
	localparam logic [1:0] SPR_RUN  = 2'd3;

	logic       odd_cycle;      // 1 = odd, 0 = even
	logic [1:0] spr_state;
	logic       dmc_state;      // DMC read armed
	dma_addr_u  src;            // Sprite source page:offset
	data_t      last_byte;      // Byte read on the even cycle
	logic [8:0] next_offset;    // Carry out marks the last pair

	assign next_offset = {1'b0, src.po.offset} + 9'd1;

	// Parity flips every CPU cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			odd_cycle <= 1'b1;
		end else if (cpu_ce) begin
			odd_cycle <= !odd_cycle;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			dmc_state <= 1'b0;
			spr_state <= SPR_IDLE;
		end else if (cpu_ce) begin
			// DMC arms on an even read cycle, fires on the next even one
			if (!dmc_state && dmc_trigger && cpu_read && !odd_cycle)
				dmc_state <= 1'b1;
			if (dmc_state && !odd_cycle)
				dmc_state <= 1'b0;  // Ack cycle done

			if (sprite_trigger)
				spr_state <= SPR_WAIT;
			if (spr_state == SPR_WAIT && cpu_read && odd_cycle)
				spr_state <= SPR_RUN;   // Reads start on the following even cycle
			// DMC steals the even cycle, sprite idles one odd cycle then resumes
			if (spr_state == SPR_RUN && !odd_cycle && dmc_state)
				spr_state <= SPR_WAIT;
			if (spr_state == SPR_RUN && odd_cycle && next_offset[8])
				spr_state <= SPR_IDLE;  // Offset wrapped, 256 pairs sent
		end
	end

	// Source address and read latch
	always_ff @(posedge clk) begin
		if (cpu_ce) begin
			if (sprite_trigger) begin
				src.po.page   <= page_data;
				src.po.offset <= 8'h00;
			end
			if (spr_state == SPR_RUN && odd_cycle)
				src.po.offset <= next_offset[7:0];  // Step after each write
			if (spr_state == SPR_RUN && !odd_cycle)
				last_byte <= rd_data;
		end
	end

	assign dmc_ack   = dmc_state && !odd_cycle;
	assign pause_cpu = (spr_state != SPR_IDLE) || dmc_trigger;  // DMC stalls at once

	always_comb begin
		dma_req.enable = dmc_ack || (spr_state == SPR_RUN);
		dma_req.read   = !odd_cycle;    // Reads even, writes odd
		dma_req.data   = last_byte;
		if (dmc_ack)
			dma_req.addr = dmc_addr;
		else if (!odd_cycle)
			dma_req.addr = src.flat;
		else
			dma_req.addr = OAM_DATA_ADDR;
	end

	// DMC read steals a cycle only while the CPU is held
	a_dmc_paused: assert property (
		@(posedge clk) disable iff (reset)
		dmc_ack |-> pause_cpu
	) else $error("sprite_dmc_dma: DMC ack while the CPU is not paused");

	// Byte read on an even sprite cycle goes out on the odd write
	a_read_then_write: assert property (
		@(posedge clk) disable iff (reset)
		(cpu_ce && spr_state == SPR_RUN && !odd_cycle && !dmc_ack)
			|=> (dma_req.enable && !dma_req.read && dma_req.data == $past(rd_data))
	) else $error("sprite_dmc_dma: sprite write does not follow its read");

endmodule

// File: cpu_data_return.sv
// Read-data return mux to the CPU and DMA with open-bus hold
`timescale 1ns/1ps

module cpu_data_return (
	input  logic                                  clk,
	input  logic                                  reset,
	input  nes_bus_pkg::chip_sel_t                sel,
	input  nes_bus_pkg::data_t                    ppu_din,
	input  nes_bus_pkg::data_t                    apu_status_din,
	input  nes_bus_pkg::data_t                    prg_din,
	input  logic                                  prg_valid,    // Cart drives the bus
	input  logic [nes_bus_pkg::JOY_BITS-1:0]      joypad1_data,
	input  logic [nes_bus_pkg::JOY_BITS-1:0]      joypad2_data,
	output nes_bus_pkg::data_t                    rd_data
);
	import nes_bus_pkg::*;

	data_t open_bus;    // Last byte seen on the bus

	// Priority order of the read sources
	always_comb begin
		if (reset) begin
			rd_data = 8'h00;
		end else if (sel.joy1) begin
			rd_data = {open_bus[7:JOY_BITS], joypad1_data};  // Upper bits float
		end else if (sel.joy2) begin
			rd_data = {open_bus[7:JOY_BITS], joypad2_data};
		end else if (sel.apu_status) begin
			rd_data = apu_status_din;
		end else if (sel.apu) begin
			rd_data = open_bus;     // Write-only APU registers
		end else if (sel.ppu) begin
			rd_data = ppu_din;
		end else if (sel.prg && prg_valid) begin
			rd_data = prg_din;
		end else begin
			rd_data = open_bus;     // Nothing drives, bus keeps its charge
		end
	end

	// Holds whatever was returned last
	always_ff @(posedge clk) begin
		open_bus <= rd_data;
	end

endmodule

// File: nes_cpu_bus.sv
// NES CPU-side bus top with decode, DMA and read return
`timescale 1ns/1ps

module nes_cpu_bus (
	input  logic                             clk,
	input  logic                             reset,
	input  logic                             cpu_ce,         // One clk per CPU cycle
	input  nes_bus_pkg::bus_req_t            cpu_req,
	input  logic                             dmc_trigger,
	input  nes_bus_pkg::addr_t               dmc_addr,
	input  nes_bus_pkg::data_t               ppu_din,
	input  nes_bus_pkg::data_t               apu_status_din,
	input  nes_bus_pkg::data_t               prg_din,
	input  logic                             prg_valid,
	input  logic [nes_bus_pkg::JOY_BITS-1:0] joypad1_data,
	input  logic [nes_bus_pkg::JOY_BITS-1:0] joypad2_data,
	output nes_bus_pkg::bus_req_t            bus,
	output nes_bus_pkg::chip_sel_t           sel,
	output nes_bus_pkg::data_t               cpu_din,
	output logic                             dmc_ack,
	output logic                             pause_cpu,
	output logic [2:0]                       joypad_out,
	output logic [1:0]                       joypad_clock
);
	import nes_bus_pkg::*;

	dma_req_t dma_req;
	logic     sprite_trigger;
	data_t    rd_data;

	cpu_bus_decode i_cpu_bus_decode (
		.clk            (clk),
		.reset          (reset),
		.cpu_req        (cpu_req),
		.dma_req        (dma_req),
		.bus            (bus),
		.sel            (sel),
		.sprite_trigger (sprite_trigger),
		.joypad_out     (joypad_out),
		.joypad_clock   (joypad_clock)
	);

	sprite_dmc_dma i_sprite_dmc_dma (
		.clk            (clk),
		.reset          (reset),
		.cpu_ce         (cpu_ce),
		.sprite_trigger (sprite_trigger),
		.page_data      (bus.data),     // Page byte of the $4014 write
		.cpu_read       (cpu_req.read),
		.dmc_trigger    (dmc_trigger),
		.dmc_addr       (dmc_addr),
		.rd_data        (rd_data),
		.dma_req        (dma_req),
		.dmc_ack        (dmc_ack),
		.pause_cpu      (pause_cpu)
	);

	cpu_data_return i_cpu_data_return (
		.clk            (clk),
		.reset          (reset),
		.sel            (sel),
		.ppu_din        (ppu_din),
		.apu_status_din (apu_status_din),
		.prg_din        (prg_din),
		.prg_valid      (prg_valid),
		.joypad1_data   (joypad1_data),
		.joypad2_data   (joypad2_data),
		.rd_data        (rd_data)
	);

	assign cpu_din = rd_data;   // Same byte goes to CPU and DMA

endmodule

// File: tb_nes_cpu_bus.sv
// Self-checking testbench for the NES CPU bus with pattern reads, joypad ports and DMA runs
`timescale 1ns/1ps

module tb_nes_cpu_bus;
	import nes_bus_pkg::*;

	localparam int N_PAT = 16;  // Accesses in bus_patterns.txt
	localparam int COLS  = 7;   // addr, wr, wdata, joy, prg_valid, src, exp

	logic                clk;
	logic                reset;
	logic                cpu_ce;
	bus_req_t            cpu_req;
	logic                dmc_trigger;
	addr_t               dmc_addr;
	data_t               ppu_din;
	data_t               apu_status_din;
	data_t               prg_din;
	logic                prg_valid;
	logic [JOY_BITS-1:0] joypad1_data;
	logic [JOY_BITS-1:0] joypad2_data;
	bus_req_t            bus;
	chip_sel_t           sel;
	data_t               cpu_din;
	logic                dmc_ack;
	logic                pause_cpu;
	logic [2:0]          joypad_out;
	logic [1:0]          joypad_clock;

	logic [15:0] pat_mem [0:N_PAT*COLS-1];
	logic [1:0]  ce_cnt;
	logic        tb_odd;    // Expected parity, 1 = odd
	data_t       last_rd;   // Byte the CPU should have seen last
	int          errors;
	int          tests;
	int          failed;
	int          mark;      // Error count when the current test began

	nes_cpu_bus i_nes_cpu_bus (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// One CPU cycle every third clk
	initial begin
		cpu_ce = 1'b0;
		ce_cnt = 2'd0;
		forever begin
			@(posedge clk);
			#1;
			ce_cnt = (ce_cnt == 2'd2) ? 2'd0 : ce_cnt + 2'd1;
			cpu_ce = (ce_cnt == 2'd2);
		end
	end

	always @(posedge clk) begin
		if (reset)
			tb_odd <= 1'b1;     // First CPU cycle after reset is odd
		else if (cpu_ce)
			tb_odd <= !tb_odd;
	end

	task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("error at %0d ns: %s, got %0h expected %0h", $time, what, actual, expected);
			errors++;
		end
	endtask

	task automatic report_test(input string name);
		tests++;
		if (errors == mark) begin
			$display("%s: ok", name);
		end else begin
			failed++;
			$display("%s: %0d mismatches", name, errors - mark);
		end
		mark = errors;
	endtask

	// Chip selects from the NES memory map
	function automatic chip_sel_t map_selects(input addr_t addr);
		chip_sel_t s;
		s.ppu        = (addr[15:13] == 3'b001);     // $2000-$3FFF
		s.apu        = (addr[15:5] == 11'h200) && (addr[4:0] <= 5'h17);  // $4000-$4017
		s.apu_status = (addr == APU_STATUS_ADDR);
		s.joy1       = (addr == JOY1_ADDR);
		s.joy2       = (addr == JOY2_ADDR);
		s.prg        = !(s.ppu || s.apu);
		return s;
	endfunction

	// Outputs are stable on the falling edge of the cpu_ce clock
	task automatic wait_sample();
		@(negedge clk);
		while (!cpu_ce)
			@(negedge clk);
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	// New CPU request with fresh chip data
	task automatic drive_access(input addr_t addr, input logic wr, input data_t wdata);
		cpu_req.addr   = addr;
		cpu_req.data   = wdata;
		cpu_req.read   = !wr;
		cpu_req.write  = wr;
		ppu_din        = data_t'($urandom);
		apu_status_din = data_t'($urandom);
		prg_din        = data_t'($urandom);
	endtask

	task automatic run_patterns();
		int    i;
		int    base;
		int    src;
		data_t want;
		for (i = 0; i < N_PAT; i++) begin
			base = i * COLS;
			joypad1_data = pat_mem[base+3][JOY_BITS-1:0];
			joypad2_data = pat_mem[base+3][JOY_BITS-1:0];
			prg_valid    = pat_mem[base+4][0];
			src          = int'(pat_mem[base+5]);
			drive_access(pat_mem[base], pat_mem[base+1][0], pat_mem[base+2][7:0]);
			wait_sample();
			check_eq(32'(sel), 32'(map_selects(pat_mem[base])),
				$sformatf("selects of %h", pat_mem[base]));
			case (src)
				0: want = ppu_din;
				1: want = apu_status_din;
				2: want = prg_din;
				3: want = last_rd;  // Nothing drives, open bus
				4: want = {last_rd[7:5], pat_mem[base+6][4:0]};
				default: want = last_rd;
			endcase
			if (src == 5) begin
				check_eq(32'(joypad_out), 32'(pat_mem[base+6][2:0]), "joypad strobe latch");
			end else begin
				check_eq(32'(cpu_din), 32'(want), $sformatf("read of %h", pat_mem[base]));
				last_rd = want;
			end
			if (src == 4)
				check_eq(32'(joypad_clock), (pat_mem[base] == JOY1_ADDR) ? 32'd1 : 32'd2,
					"joypad clock pulse");
			next_cycle();
		end
	endtask

	task automatic dmc_alone();
		int n;
		n = 0;
		dmc_addr    = 16'hC123;
		dmc_trigger = 1'b1;
		drive_access(16'h8000, 1'b0, 8'h00);
		wait_sample();
		check_eq(32'(pause_cpu), 32'd1, "pause_cpu on DMC trigger");
		while (!dmc_ack && n < 8) begin
			next_cycle();
			drive_access(16'h8000, 1'b0, 8'h00);
			wait_sample();
			n++;
		end
		if (!dmc_ack) begin
			$display("DMC test: dmc_ack never came");
			errors++;
		end
		check_eq(32'(tb_odd), 32'd0, "DMC ack parity");
		check_eq(32'(bus.addr), 32'(dmc_addr), "DMC address");
		check_eq(32'(bus.read), 32'd1, "DMC read");
		next_cycle();
		dmc_trigger = 1'b0;
		drive_access(16'h8000, 1'b0, 8'h00);
		wait_sample();
		check_eq(32'(pause_cpu), 32'd0, "pause_cpu after DMC");
		next_cycle();
	endtask

	// Sprite DMA of one page, with an optional DMC read dropped in at pair 100
	task automatic sprite_dma(input data_t page, input logic with_dmc);
		int    n;
		int    pairs;
		int    dmc_reads;
		logic  have_byte;
		data_t held;    // Byte read on the last even cycle
		n         = 0;
		pairs     = 0;
		dmc_reads = 0;
		have_byte = 1'b0;
		held      = 8'h00;
		prg_valid = 1'b1;
		drive_access(OAM_DMA_ADDR, 1'b1, page);
		wait_sample();
		next_cycle();
		drive_access(16'h8000, 1'b0, 8'h00);    // Halted CPU keeps reading
		wait_sample();
		check_eq(32'(pause_cpu), 32'd1, "pause_cpu after page write");
		while (pause_cpu && n < 600) begin
			if (dmc_ack) begin
				check_eq(32'(bus.addr), 32'(dmc_addr), "DMC address inside sprite DMA");
				check_eq(32'(tb_odd), 32'd0, "DMC ack parity");
				dmc_reads++;
			end else if (bus.read && bus.addr[15:8] == page) begin
				check_eq(32'(bus.addr[7:0]), 32'(pairs), "sprite read offset");
				check_eq(32'(tb_odd), 32'd0, "sprite read parity");
				check_eq(32'(cpu_din), 32'(prg_din), "sprite read data");
				held      = prg_din;
				have_byte = 1'b1;
			end else if (bus.write && bus.addr == OAM_DATA_ADDR) begin
				check_eq(32'(have_byte), 32'd1, "OAM write without a read before it");
				check_eq(32'(bus.data), 32'(held), "OAM write data");
				have_byte = 1'b0;
				pairs++;
			end
			next_cycle();
			dmc_trigger = with_dmc && pairs >= 100 && dmc_reads == 0;
			drive_access(16'h8000, 1'b0, 8'h00);
			wait_sample();
			n++;
		end
		if (pause_cpu) begin
			$display("Sprite DMA test: pause_cpu never fell");
			errors++;
		end
		check_eq(32'(pairs), 32'd256, "sprite read/write pairs");
		check_eq(32'(dmc_reads), with_dmc ? 32'd1 : 32'd0, "DMC reads inside sprite DMA");
		next_cycle();
	endtask

	initial begin
		reset          = 1'b1;
		cpu_req        = '0;
		dmc_trigger    = 1'b0;
		dmc_addr       = '0;
		ppu_din        = '0;
		apu_status_din = '0;
		prg_din        = '0;
		prg_valid      = 1'b0;
		joypad1_data   = '0;
		joypad2_data   = '0;
		errors         = 0;
		tests          = 0;
		failed         = 0;
		mark           = 0;
		last_rd        = 8'h00;     // Return path reads zero in reset
		void'($urandom(32'hdd19));
		$readmemh("bus_patterns.txt", pat_mem);
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
		drive_access(16'hA5C3, 1'b0, 8'h5A);   // Cart read with nothing driving
		wait_sample();
		check_eq(32'(pause_cpu), 32'd0, "pause_cpu after reset");
		check_eq(32'(dmc_ack), 32'd0, "dmc_ack after reset");
		check_eq(32'(joypad_clock), 32'd0, "joypad_clock after reset");
		check_eq(32'(bus), 32'(cpu_req), "bus follows cpu_req");
		report_test("reset state");
		next_cycle();
		run_patterns();
		report_test("pattern reads and joypad");
		dmc_alone();
		report_test("DMC read alone");
		sprite_dma(8'h03, 1'b0);
		report_test("sprite DMA");
		sprite_dma(8'h05, 1'b1);
		report_test("sprite DMA with DMC read");
		$display("%0d tests, %0d failed, %0d mismatches", tests, failed, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	// Watchdog sized from the pattern count plus the DMA runs
	initial begin
		#((N_PAT + 1200) * 30);
		$display("Timeout: the run did not finish in the expected time");
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// File: bus_patterns.txt
// Columns: addr wr wdata joy prg_valid src exp (src 0 ppu, 1 apu status, 2 prg, 3 open bus)
// src 4 joypad read with exp as pad bits, src 5 joy1 write with exp as joypad_out
2002 0 00 00 0 0 00
4000 0 00 00 0 3 00
3FFF 0 00 00 0 0 00
4015 0 00 00 0 1 00
4008 0 00 00 0 3 00
8000 0 00 00 1 2 00
FFFC 0 00 00 0 3 00
6000 0 00 00 1 2 00
4016 0 00 15 0 4 15
4017 0 00 0A 0 4 0A
4016 1 05 00 0 5 05
2007 0 00 00 0 0 00
4017 0 00 1F 0 4 1F
4016 1 02 00 0 5 02
C000 0 00 00 1 2 00
2003 0 00 00 0 0 00

// File: list.f
nes_bus_pkg.sv
cpu_bus_decode.sv
sprite_dmc_dma.sv
cpu_data_return.sv
nes_cpu_bus.sv
tb_nes_cpu_bus.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_nes_cpu_bus
FILELIST  = list.f
BUILD_DIR = obj_dir
LOG       = sim.log
FAIL_MSG  = SOME TESTS FAILED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
